// File: rtl/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// PC and target width
`define BP_ADDR_BITS  32

// Tables are indexed by PC[BP_INDEX_BITS+1:2]
`define BP_INDEX_BITS 5

// Must equal 1 << BP_INDEX_BITS
`define BP_ENTRIES    32

`endif

// File: rtl/bp_pkg.sv
`include "bp_cfg.svh"

package bp_pkg;

    // 2-bit saturating counter, MSB set means predict taken
    typedef enum logic [1:0] {
        CNT_NOT_TAKEN      = 2'b00,
        CNT_WEAK_NOT_TAKEN = 2'b01,
        CNT_WEAK_TAKEN     = 2'b10,
        CNT_TAKEN          = 2'b11
    } bp_counter_e;

    typedef logic [`BP_INDEX_BITS-1:0] bp_index_t;
    typedef logic [`BP_ADDR_BITS-1:0]  bp_addr_t;

    // Lookup result for one fetch stage
    typedef struct packed {
        logic     hit;    // Predicted taken
        bp_addr_t target; // Word aligned
    } bp_prediction_t;

    // Resolved branch from execute, with the prediction it was fetched under
    typedef struct packed {
        bp_addr_t pc;
        logic     taken;
        bp_addr_t target;
        logic     pred_taken;
        bp_addr_t pred_target;
    } bp_resolve_t;

    // Table update request, issued only on a miss
    typedef struct packed {
        bp_index_t index;
        logic      taken;
        bp_addr_t  target; // Already aligned
    } bp_update_t;

endpackage

// File: rtl/branch_table.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module branch_table import bp_pkg::*; #(
    parameter type      payload_t   = bp_addr_t,
    parameter payload_t RESET_VALUE = payload_t'(0)
) (
    input  logic      clk,
    input  logic      rst_n,

    // Lookup ports
    input  bp_index_t rd_idx_a_i,
    input  bp_index_t rd_idx_b_i,
    output payload_t  rd_data_a_o,
    output payload_t  rd_data_b_o,

    // Read at the update index, feeds read-modify-write
    input  bp_index_t rd_idx_u_i,
    output payload_t  rd_data_u_o,

    input  logic      wr_en_i,
    input  bp_index_t wr_idx_i,
    input  payload_t  wr_data_i
);

    payload_t entries [`BP_ENTRIES];

    // Asynchronous reads, writes land at the next edge
    assign rd_data_a_o = entries[rd_idx_a_i];
    assign rd_data_b_o = entries[rd_idx_b_i];
    assign rd_data_u_o = entries[rd_idx_u_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                entries[i] <= RESET_VALUE;
            end
        end else if (wr_en_i) begin
            entries[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

// File: rtl/predictor_core.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module predictor_core import bp_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,

    input  bp_addr_t       lookup_pc_2_i,
    input  bp_addr_t       lookup_pc_4_i,
    output bp_prediction_t pred_2_o,
    output bp_prediction_t pred_4_o,

    input  logic           upd_valid_i,
    input  bp_update_t     upd_i
);

    bp_index_t   idx_2;
    bp_index_t   idx_4;

    bp_counter_e cnt_2;
    bp_counter_e cnt_4;
    bp_counter_e cnt_cur; // Counter at the update index
    bp_counter_e cnt_next;

    bp_addr_t    tgt_2;
    bp_addr_t    tgt_4;
    bp_addr_t    tgt_cur;
    bp_addr_t    tgt_aligned;
    logic        tgt_wr_en;

    function automatic logic predict_taken(bp_counter_e cnt);
        return (cnt == CNT_WEAK_TAKEN) || (cnt == CNT_TAKEN);
    endfunction

    assign idx_2 = lookup_pc_2_i[`BP_INDEX_BITS+1:2];
    assign idx_4 = lookup_pc_4_i[`BP_INDEX_BITS+1:2];

    // One step toward the resolved direction, saturating at both ends
    always_comb begin
        cnt_next = cnt_cur;
        if (upd_i.taken) begin
            case (cnt_cur)
                CNT_NOT_TAKEN:      cnt_next = CNT_WEAK_NOT_TAKEN;
                CNT_WEAK_NOT_TAKEN: cnt_next = CNT_WEAK_TAKEN;
                default:            cnt_next = CNT_TAKEN;
            endcase
        end else begin
            case (cnt_cur)
                CNT_TAKEN:      cnt_next = CNT_WEAK_TAKEN;
                CNT_WEAK_TAKEN: cnt_next = CNT_WEAK_NOT_TAKEN;
                default:        cnt_next = CNT_NOT_TAKEN;
            endcase
        end
    end

    assign tgt_aligned = {upd_i.target[`BP_ADDR_BITS-1:2], 2'b00};

    // Not-taken updates keep the old target; skip writes that change nothing
    assign tgt_wr_en = upd_valid_i && upd_i.taken && (tgt_cur != tgt_aligned);

    branch_table #(
        .payload_t   (bp_counter_e),
        .RESET_VALUE (CNT_WEAK_NOT_TAKEN)
    ) u_counter_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_idx_a_i  (idx_2),
        .rd_idx_b_i  (idx_4),
        .rd_data_a_o (cnt_2),
        .rd_data_b_o (cnt_4),
        .rd_idx_u_i  (upd_i.index),
        .rd_data_u_o (cnt_cur),
        .wr_en_i     (upd_valid_i),
        .wr_idx_i    (upd_i.index),
        .wr_data_i   (cnt_next)
    );

    branch_table #(
        .payload_t   (bp_addr_t),
        .RESET_VALUE ('0)
    ) u_target_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_idx_a_i  (idx_2),
        .rd_idx_b_i  (idx_4),
        .rd_data_a_o (tgt_2),
        .rd_data_b_o (tgt_4),
        .rd_idx_u_i  (upd_i.index),
        .rd_data_u_o (tgt_cur),
        .wr_en_i     (tgt_wr_en),
        .wr_idx_i    (upd_i.index),
        .wr_data_i   (tgt_aligned)
    );

    assign pred_2_o.hit    = predict_taken(cnt_2);
    assign pred_2_o.target = tgt_2;
    assign pred_4_o.hit    = predict_taken(cnt_4);
    assign pred_4_o.target = tgt_4;

endmodule

// File: rtl/resolve_unit.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module resolve_unit import bp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // Execute stage, one-cycle strobe
    input  logic        resolve_valid_i,
    input  bp_resolve_t resolve_i,

    // Registered update request toward the tables
    output logic        upd_valid_o,
    output bp_update_t  upd_o
);

    bp_addr_t target_aligned;
    logic     dir_miss;
    logic     tgt_miss;
    logic     miss;

    assign target_aligned = {resolve_i.target[`BP_ADDR_BITS-1:2], 2'b00};

    assign dir_miss = resolve_i.taken != resolve_i.pred_taken;

    // Right direction but fetch went to the wrong place
    assign tgt_miss = resolve_i.taken && resolve_i.pred_taken
                   && (target_aligned != resolve_i.pred_target);

    assign miss = resolve_valid_i && (dir_miss || tgt_miss);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd_valid_o <= 1'b0;
        end else begin
            upd_valid_o <= miss; // Drops again after one cycle unless another miss
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            upd_o.index  <= resolve_i.pc[`BP_INDEX_BITS+1:2];
            upd_o.taken  <= resolve_i.taken;
            upd_o.target <= target_aligned;
        end
    end

endmodule

// File: rtl/bp_top.sv
`timescale 1ns/1ns

module bp_top import bp_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           resolve_valid_i,
    input  bp_resolve_t    resolve_i,

    // Fetch stage 2 and stage 4 lookups
    input  bp_addr_t       lookup_pc_2_i,
    input  bp_addr_t       lookup_pc_4_i,
    output bp_prediction_t pred_2_o,
    output bp_prediction_t pred_4_o
);

    logic       upd_valid;
    bp_update_t upd;

    resolve_unit u_resolve (
        .clk             (clk),
        .rst_n           (rst_n),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .upd_valid_o     (upd_valid),
        .upd_o           (upd)
    );

    predictor_core u_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_pc_2_i (lookup_pc_2_i),
        .lookup_pc_4_i (lookup_pc_4_i),
        .pred_2_o      (pred_2_o),
        .pred_4_o      (pred_4_o),
        .upd_valid_i   (upd_valid),
        .upd_i         (upd)
    );

endmodule

// File: test/bp_assertions.sv
`timescale 1ns/1ns

module bp_assertions import bp_pkg::*; (
    input logic           clk,
    input logic           rst_n,
    input logic           resolve_valid_i,
    input logic           upd_valid_i,
    input bp_prediction_t pred_2_i,
    input bp_prediction_t pred_4_i
);

    // Update strobe is always one cycle behind a resolve strobe
    upd_follows_resolve: assert property (@(posedge clk) disable iff (!rst_n)
        upd_valid_i |-> $past(resolve_valid_i))
        else $error("upd_valid high without a resolve strobe one cycle earlier");

    upd_low_in_reset: assert property (@(posedge clk)
        !rst_n |=> !upd_valid_i)
        else $error("upd_valid high during or right after reset");

    pred_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(pred_2_i) && !$isunknown(pred_4_i))
        else $error("prediction output has unknown bits");

endmodule

bind bp_top bp_assertions u_assertions (
    .clk             (clk),
    .rst_n           (rst_n),
    .resolve_valid_i (resolve_valid_i),
    .upd_valid_i     (upd_valid),
    .pred_2_i        (pred_2_o),
    .pred_4_i        (pred_4_o)
);

// File: test/tb_top.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module tb_top import bp_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 400;
    // Reset, then tests 1 to 6 with the drain cycles of the random run
    localparam int TEST_CYCLES   = RESET_CYCLES + 8 + 14 + 6 + 6 + 2 + RANDOM_CYCLES + 2;
    localparam int MARGIN_CYCLES = 100;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic           clk;
    logic           rst_n;
    logic           resolve_valid;
    bp_resolve_t    resolve;
    bp_addr_t       lookup_pc_2;
    bp_addr_t       lookup_pc_4;
    bp_prediction_t pred_2;
    bp_prediction_t pred_4;

    // Reference model state
    int unsigned    model_cnt [`BP_ENTRIES];
    bp_addr_t       model_tgt [`BP_ENTRIES];
    logic           pend_valid; // Mirrors the registered update request
    bp_update_t     pend;

    int             check_count;
    int             error_count;
    int unsigned    seed_init;

    // Small pool, several PCs share an index
    bp_addr_t pc_pool [8] = '{32'h0000_0100, 32'h0000_0180, 32'h0000_1104, 32'h8000_0004,
                              32'h0000_0048, 32'h0001_0048, 32'h0000_007C, 32'h0000_00FC};

    bp_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .resolve_valid_i (resolve_valid),
        .resolve_i       (resolve),
        .lookup_pc_2_i   (lookup_pc_2),
        .lookup_pc_4_i   (lookup_pc_4),
        .pred_2_o        (pred_2),
        .pred_4_o        (pred_4)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic bp_index_t index_of(bp_addr_t pc);
        return pc[`BP_INDEX_BITS+1:2];
    endfunction

    function automatic bp_prediction_t pred_value(logic hit, bp_addr_t target);
        bp_prediction_t p;
        p.hit    = hit;
        p.target = target;
        return p;
    endfunction

    function automatic bp_prediction_t model_pred(bp_addr_t pc);
        bp_prediction_t p;
        p.hit    = model_cnt[index_of(pc)] >= 2; // Weak or strong taken
        p.target = model_tgt[index_of(pc)];
        return p;
    endfunction

    function automatic bp_resolve_t make_resolve(bp_addr_t pc, logic taken, bp_addr_t target,
                                                 logic pred_taken, bp_addr_t pred_target);
        bp_resolve_t res;
        res.pc          = pc;
        res.taken       = taken;
        res.target      = target;
        res.pred_taken  = pred_taken;
        res.pred_target = pred_target;
        return res;
    endfunction

    // Called right after each rising edge
    task automatic model_clock();
        bp_addr_t aligned;
        logic     miss;
        if (pend_valid) begin
            if (pend.taken) begin
                if (model_cnt[pend.index] < 3) model_cnt[pend.index] = model_cnt[pend.index] + 1;
                model_tgt[pend.index] = pend.target;
            end else if (model_cnt[pend.index] > 0) begin
                model_cnt[pend.index] = model_cnt[pend.index] - 1;
            end
        end
        aligned = {resolve.target[`BP_ADDR_BITS-1:2], 2'b00};
        miss = (resolve.taken != resolve.pred_taken)
            || (resolve.taken && resolve.pred_taken && (aligned != resolve.pred_target));
        pend_valid   = resolve_valid && miss;
        pend.index   = index_of(resolve.pc);
        pend.taken   = resolve.taken;
        pend.target  = aligned;
    endtask

    task automatic check_prediction(string name, bp_prediction_t actual,
                                    bp_prediction_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: hit 0x%h expected 0x%h, target 0x%h expected 0x%h",
                     name, actual.hit, expected.hit, actual.target, expected.target);
        end
    endtask

    // Drive on the falling edge, check at the next falling edge
    task automatic run_cycle(logic valid, bp_resolve_t res, bp_addr_t pc2, bp_addr_t pc4);
        resolve_valid = valid;
        resolve       = res;
        lookup_pc_2   = pc2;
        lookup_pc_4   = pc4;
        @(posedge clk);
        model_clock();
        @(negedge clk);
        check_prediction("pred_2_o", pred_2, model_pred(pc2));
        check_prediction("pred_4_o", pred_4, model_pred(pc4));
    endtask

    task automatic idle_cycle(bp_addr_t pc2, bp_addr_t pc4);
        run_cycle(1'b0, '0, pc2, pc4);
    endtask

    task automatic expect_both(bp_prediction_t expected);
        check_prediction("pred_2_o", pred_2, expected);
        check_prediction("pred_4_o", pred_4, expected);
    endtask

    // Strobe, wait for the write, then look at the entry on both ports
    task automatic resolve_then_expect(bp_resolve_t res, bp_prediction_t expected);
        run_cycle(1'b1, res, res.pc, res.pc);
        idle_cycle(res.pc, res.pc);
        expect_both(expected);
    endtask

    task automatic finish_test(string name, int errors_before);
        $display("Test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset_state();
        int start;
        start = error_count;
        repeat (8) begin
            idle_cycle($urandom, $urandom);
            expect_both(pred_value(1'b0, 32'h0));
        end
        finish_test("reset_state", start);
    endtask

    task automatic test_training();
        int       start;
        bp_addr_t pc;
        bp_addr_t tgt;
        start = error_count;
        pc    = 32'h0000_100E; // Index 3
        tgt   = 32'h0000_2347;
        resolve_then_expect(make_resolve(pc, 1'b0, 32'h0, 1'b1, 32'h0), pred_value(1'b0, 32'h0));
        resolve_then_expect(make_resolve(pc, 1'b1, tgt, 1'b0, 32'h0),
                            pred_value(1'b0, 32'h0000_2344));
        resolve_then_expect(make_resolve(pc, 1'b1, tgt, 1'b0, 32'h0),
                            pred_value(1'b1, 32'h0000_2344));
        resolve_then_expect(make_resolve(pc, 1'b1, tgt, 1'b0, 32'h0),
                            pred_value(1'b1, 32'h0000_2344));
        resolve_then_expect(make_resolve(pc, 1'b1, tgt, 1'b0, 32'h0),
                            pred_value(1'b1, 32'h0000_2344)); // Saturated
        resolve_then_expect(make_resolve(pc, 1'b0, 32'h0, 1'b1, 32'h0),
                            pred_value(1'b1, 32'h0000_2344));
        resolve_then_expect(make_resolve(pc, 1'b0, 32'h0, 1'b1, 32'h0),
                            pred_value(1'b0, 32'h0000_2344));
        finish_test("training", start);
    endtask

    task automatic test_correct_prediction();
        int       start;
        bp_addr_t pc;
        start = error_count;
        pc    = 32'h0000_0014; // Index 5
        // A stray write here would set hit and the target
        resolve_then_expect(make_resolve(pc, 1'b1, 32'h0000_5001, 1'b1, 32'h0000_5000),
                            pred_value(1'b0, 32'h0));
        resolve_then_expect(make_resolve(pc, 1'b1, 32'h0000_3000, 1'b0, 32'h0),
                            pred_value(1'b1, 32'h0000_3000));
        // One stray step from weak taken would clear hit
        resolve_then_expect(make_resolve(pc, 1'b0, 32'h0000_5000, 1'b0, 32'h0000_5000),
                            pred_value(1'b1, 32'h0000_3000));
        finish_test("correct_prediction", start);
    endtask

    task automatic test_target_miss();
        int       start;
        bp_addr_t pc;
        start = error_count;
        pc    = 32'h0000_001C; // Index 7
        resolve_then_expect(make_resolve(pc, 1'b1, 32'h0000_4000, 1'b0, 32'h0),
                            pred_value(1'b1, 32'h0000_4000));
        resolve_then_expect(make_resolve(pc, 1'b1, 32'h0000_4102, 1'b1, 32'h0000_4000),
                            pred_value(1'b1, 32'h0000_4100));
        // Strong taken survives one not-taken miss
        resolve_then_expect(make_resolve(pc, 1'b0, 32'h0, 1'b1, 32'h0000_4100),
                            pred_value(1'b1, 32'h0000_4100));
        finish_test("target_miss", start);
    endtask

    task automatic test_latency();
        int          start;
        bp_resolve_t res;
        start = error_count;
        res   = make_resolve(32'h0000_0024, 1'b1, 32'h4000_0002, 1'b0, 32'h0); // Index 9
        run_cycle(1'b1, res, 32'h0000_0024, 32'h0000_10A4); // Port 4 aliases index 9
        expect_both(pred_value(1'b0, 32'h0));
        idle_cycle(32'h0000_0024, 32'h0000_10A4);
        expect_both(pred_value(1'b1, 32'h4000_0000));
        finish_test("latency", start);
    endtask

    task automatic test_random();
        int             start;
        int unsigned    r;
        bp_resolve_t    res;
        bp_prediction_t cur;
        bp_addr_t       pc4;
        start = error_count;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r   = $urandom;
            res.pc    = pc_pool[r[2:0]];
            res.taken = r[3];
            cur = model_pred(res.pc);
            res.pred_taken  = (r[5:4] == 2'b00) ? ~cur.hit : cur.hit; // Forced misses
            res.pred_target = (r[7:6] == 2'b00) ? $urandom : cur.target;
            res.target      = r[8] ? {cur.target[`BP_ADDR_BITS-1:2], r[10:9]} : $urandom;
            pc4 = r[17] ? pc_pool[r[20:18]] : $urandom;
            run_cycle(r[12:11] != 2'b00, res, pc_pool[r[16:14]], pc4);
        end
        idle_cycle(pc_pool[0], pc_pool[4]);
        idle_cycle(pc_pool[2], pc_pool[6]);
        finish_test("random", start);
    endtask

    initial begin
        seed_init     = $urandom(19);
        rst_n         = 1'b0;
        resolve_valid = 1'b0;
        resolve       = '0;
        lookup_pc_2   = '0;
        lookup_pc_4   = '0;
        pend_valid    = 1'b0;
        pend          = '0;
        check_count   = 0;
        error_count   = 0;
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            model_cnt[i] = 1; // Weak not taken
            model_tgt[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_training();
        test_correct_prediction();
        test_target_miss();
        test_latency();
        test_random();

        $display("Summary: %0d checks, %0d passed, %0d failed",
                 check_count, check_count - error_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/branch_table.sv
rtl/predictor_core.sv
rtl/resolve_unit.sv
rtl/bp_top.sv
test/bp_assertions.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f src.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
